//--- src.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/rv_op_decode.sv
logic/rv_operand_gen.sv
logic/rv_decode_reg.sv
logic/rv_decode_stage.sv
tb/tb_rv_decode_stage.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f src.f --top-module tb_rv_decode_stage \
  -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -qx ">>> PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/tb_rv_decode_stage.sv
`timescale 1ns/1ps

module tb_rv_decode_stage;
  import rv_decode_pkg::*;

  localparam int N_VEC = 3000;

  // Operand format kinds used by the encoder
  localparam logic [2:0] K_R  = 3'd0;
  localparam logic [2:0] K_I  = 3'd1;
  localparam logic [2:0] K_SH = 3'd2;
  localparam logic [2:0] K_S  = 3'd3;
  localparam logic [2:0] K_B  = 3'd4;
  localparam logic [2:0] K_U  = 3'd5;
  localparam logic [2:0] K_J  = 3'd6;
  localparam logic [2:0] K_N  = 3'd7;

  logic        clk;
  logic        rst;
  logic        ifu_vld;
  rv_inst_u    ifu_inst;
  logic [31:0] ifu_pc;
  logic        alu_vld;
  logic        alu_br_miss;
  logic        idu_vld;
  rv_uop_s     idu_uop;

  integer  seed = 84;
  int      err_cnt = 0;
  logic    chk_en;
  logic    exp_vld;
  logic    exp_vld_nxt;
  rv_uop_s exp_uop;
  rv_uop_s exp_uop_nxt; // Registered by the DUT at the coming edge

  rv_decode_stage i_dut (
    .clk         (clk),
    .rst         (rst),
    .ifu_vld     (ifu_vld),
    .ifu_inst    (ifu_inst),
    .ifu_pc      (ifu_pc),
    .alu_vld     (alu_vld),
    .alu_br_miss (alu_br_miss),
    .idu_vld     (idu_vld),
    .idu_uop     (idu_uop)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // {kind, opcode, funct3, funct7} from the RV32I base table
  function automatic logic [19:0] op_encoding(input rv_op_e op);
    case (op)
      OP_LUI:    return {K_U, 7'h37, 3'd0, 7'h00};
      OP_AUIPC:  return {K_U, 7'h17, 3'd0, 7'h00};
      OP_JAL:    return {K_J, 7'h6f, 3'd0, 7'h00};
      OP_JALR:   return {K_I, 7'h67, 3'd0, 7'h00};
      OP_BEQ:    return {K_B, 7'h63, 3'd0, 7'h00};
      OP_BNE:    return {K_B, 7'h63, 3'd1, 7'h00};
      OP_BLT:    return {K_B, 7'h63, 3'd4, 7'h00};
      OP_BGE:    return {K_B, 7'h63, 3'd5, 7'h00};
      OP_BLTU:   return {K_B, 7'h63, 3'd6, 7'h00};
      OP_BGEU:   return {K_B, 7'h63, 3'd7, 7'h00};
      OP_LB:     return {K_I, 7'h03, 3'd0, 7'h00};
      OP_LH:     return {K_I, 7'h03, 3'd1, 7'h00};
      OP_LW:     return {K_I, 7'h03, 3'd2, 7'h00};
      OP_LBU:    return {K_I, 7'h03, 3'd4, 7'h00};
      OP_LHU:    return {K_I, 7'h03, 3'd5, 7'h00};
      OP_SB:     return {K_S, 7'h23, 3'd0, 7'h00};
      OP_SH:     return {K_S, 7'h23, 3'd1, 7'h00};
      OP_SW:     return {K_S, 7'h23, 3'd2, 7'h00};
      OP_ADDI:   return {K_I, 7'h13, 3'd0, 7'h00};
      OP_SLTI:   return {K_I, 7'h13, 3'd2, 7'h00};
      OP_SLTIU:  return {K_I, 7'h13, 3'd3, 7'h00};
      OP_XORI:   return {K_I, 7'h13, 3'd4, 7'h00};
      OP_ORI:    return {K_I, 7'h13, 3'd6, 7'h00};
      OP_ANDI:   return {K_I, 7'h13, 3'd7, 7'h00};
      OP_SLLI:   return {K_SH, 7'h13, 3'd1, 7'h00};
      OP_SRLI:   return {K_SH, 7'h13, 3'd5, 7'h00};
      OP_SRAI:   return {K_SH, 7'h13, 3'd5, 7'h20};
      OP_ADD:    return {K_R, 7'h33, 3'd0, 7'h00};
      OP_SUB:    return {K_R, 7'h33, 3'd0, 7'h20};
      OP_SLL:    return {K_R, 7'h33, 3'd1, 7'h00};
      OP_SLT:    return {K_R, 7'h33, 3'd2, 7'h00};
      OP_SLTU:   return {K_R, 7'h33, 3'd3, 7'h00};
      OP_XOR:    return {K_R, 7'h33, 3'd4, 7'h00};
      OP_SRL:    return {K_R, 7'h33, 3'd5, 7'h00};
      OP_SRA:    return {K_R, 7'h33, 3'd5, 7'h20};
      OP_OR:     return {K_R, 7'h33, 3'd6, 7'h00};
      OP_AND:    return {K_R, 7'h33, 3'd7, 7'h00};
      OP_FENCE:  return {K_N, 7'h0f, 3'd0, 7'h00};
      OP_ECALL:  return {K_N, 7'h73, 3'd0, 7'h00};
      OP_EBREAK: return {K_N, 7'h73, 3'd0, 7'h01}; // Low bit picks imm 1
      default:   return '0;
    endcase
  endfunction

  task automatic encode_kept(input rv_op_e op, output rv_inst_u w, output rv_uop_s u);
    logic [2:0]  kind;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] r;
    logic [31:0] imm;
    {kind, opc, f3, f7} = op_encoding(op);
    r   = $random(seed); // Register fields at their instruction positions
    imm = $random(seed);
    u = '0;
    u.op = op;
    case (kind)
      K_R: begin
        w = {f7, r[24:20], r[19:15], f3, r[11:7], opc};
        u.opnd.rs1 = r[19:15];
        u.opnd.rs2 = r[24:20];
        u.opnd.rd  = r[11:7];
      end
      K_I: begin
        w = {imm[11:0], r[19:15], f3, r[11:7], opc};
        u.opnd.rs1 = r[19:15];
        u.opnd.rd  = r[11:7];
        u.opnd.imm = {20'd0, imm[11:0]};
      end
      K_SH: begin
        w = {f7, imm[4:0], r[19:15], f3, r[11:7], opc};
        u.opnd.rs1 = r[19:15];
        u.opnd.rd  = r[11:7];
        u.opnd.imm = {27'd0, imm[4:0]};
      end
      K_S: begin
        w = {imm[11:5], r[24:20], r[19:15], f3, imm[4:0], opc};
        u.opnd.rs1 = r[19:15];
        u.opnd.rs2 = r[24:20];
        u.opnd.imm = {20'd0, imm[11:0]};
      end
      K_B: begin
        w = {imm[12], imm[10:5], r[24:20], r[19:15], f3, imm[4:1], imm[11], opc};
        u.opnd.rs1 = r[19:15];
        u.opnd.rs2 = r[24:20];
        u.opnd.imm = {19'd0, imm[12:1], 1'b0};
      end
      K_U: begin
        w = {imm[31:12], r[11:7], opc};
        u.opnd.rd  = r[11:7];
        u.opnd.imm = {imm[31:12], 12'd0};
      end
      K_J: begin
        w = {imm[20], imm[10:1], imm[11], imm[19:12], r[11:7], opc};
        u.opnd.rd  = r[11:7];
        u.opnd.imm = {11'd0, imm[20:1], 1'b0};
      end
      default: begin
        if (opc == 7'h73) w = {11'd0, f7[0], 13'd0, opc};
        else w = {r[31:15], f3, r[11:7], opc}; // FENCE with random fm/pred/succ
      end
    endcase
  endtask

  task automatic encode_illegal(output rv_inst_u w, output rv_uop_s u);
    logic [31:0] r;
    logic [2:0]  f3;
    int          sel;
    r   = $random(seed);
    f3  = r[14:12];
    sel = $unsigned($random(seed)) % 11;
    u = '0;
    u.op = OP_TRAP;
    case (sel)
      0: w = {r[31:1], 1'b0}; // Opcode low bits not 11
      1: w = {r[31:7], 7'h2f}; // AMO
      2: w = {r[31:15], (f3 == 3'd0) ? 3'd1 : f3, r[11:7], 7'h73}; // CSR
      3: w = {(r[31:20] < 12'd2) ? 12'h302 : r[31:20], r[19:15], 3'd0, r[11:7], 7'h73};
      4: w = {r[31:15], 2'b01, r[12], r[11:7], 7'h63};
      5: w = {r[31:15], r[12] ? 3'd3 : {2'b11, r[13]}, r[11:7], 7'h03};
      6: w = {r[31:15], r[14] ? {1'b1, r[13:12]} : 3'd3, r[11:7], 7'h23};
      7: w = {r[31:15], (f3 == 3'd0) ? 3'd1 : f3, r[11:7], r[31] ? 7'h67 : 7'h0f};
      8: w = {r[31:25] | 7'h01, r[24:12], r[11:7], 7'h33}; // Odd funct7
      9: w = {7'h20, r[24:15], (f3 == 3'd0 || f3 == 3'd5) ? 3'd2 : f3, r[11:7], 7'h33};
      default: w = {r[31:25] | 7'h01, r[24:15], r[14], 2'b01, r[11:7], 7'h13};
    endcase
  endtask

  task automatic apply_cycle(input logic rst_in, input logic vld, input rv_inst_u w,
                             input rv_uop_s u, input logic a_vld, input logic miss);
    @(negedge clk);
    exp_vld     = exp_vld_nxt;
    exp_uop     = exp_uop_nxt;
    chk_en      = 1'b1;
    rst         = rst_in;
    ifu_vld     = vld;
    ifu_inst    = w;
    ifu_pc      = u.pc;
    alu_vld     = a_vld;
    alu_br_miss = miss;
    exp_vld_nxt = !rst_in && vld && !(a_vld && miss);
    exp_uop_nxt = u;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    err_cnt++;
    $display("error %s: expected %0h, actual %0h", name, exp, act);
    $display(">>> FAIL");
    $fatal(1, "check %s failed", name);
  endtask

  a_vld: assert property (@(posedge clk) chk_en |-> idu_vld == exp_vld)
    else report_mismatch("valid", 32'(exp_vld), 32'($sampled(idu_vld)));
  a_op: assert property (@(posedge clk) chk_en |-> idu_uop.op == exp_uop.op)
    else report_mismatch("op", 32'(exp_uop.op), 32'($sampled(idu_uop.op)));
  a_rs1: assert property (@(posedge clk) chk_en |-> idu_uop.opnd.rs1 == exp_uop.opnd.rs1)
    else report_mismatch("rs1", 32'(exp_uop.opnd.rs1), 32'($sampled(idu_uop.opnd.rs1)));
  a_rs2: assert property (@(posedge clk) chk_en |-> idu_uop.opnd.rs2 == exp_uop.opnd.rs2)
    else report_mismatch("rs2", 32'(exp_uop.opnd.rs2), 32'($sampled(idu_uop.opnd.rs2)));
  a_rd: assert property (@(posedge clk) chk_en |-> idu_uop.opnd.rd == exp_uop.opnd.rd)
    else report_mismatch("rd", 32'(exp_uop.opnd.rd), 32'($sampled(idu_uop.opnd.rd)));
  a_imm: assert property (@(posedge clk) chk_en |-> idu_uop.opnd.imm == exp_uop.opnd.imm)
    else report_mismatch("imm", exp_uop.opnd.imm, $sampled(idu_uop.opnd.imm));
  a_pc: assert property (@(posedge clk) chk_en |-> idu_uop.pc == exp_uop.pc)
    else report_mismatch("pc", exp_uop.pc, $sampled(idu_uop.pc));

  initial begin
    #((N_VEC + 20) * 20);
    $display("timeout: run did not finish within %0d ns", (N_VEC + 20) * 20);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] r;
    logic [31:0] pc;
    logic [5:0]  idx;
    rv_inst_u    w;
    rv_uop_s     u;
    rst         = 1'b1;
    ifu_vld     = 1'b0;
    ifu_inst    = '0;
    ifu_pc      = '0;
    alu_vld     = 1'b0;
    alu_br_miss = 1'b0;
    chk_en      = 1'b0;
    exp_vld     = 1'b0;
    exp_uop     = '0;
    exp_vld_nxt = 1'b0;
    exp_uop_nxt = '0;
    exp_uop_nxt.op = OP_TRAP; // All-zero word
    pc = 32'h0000_1000;
    repeat (2) begin
      encode_kept(OP_ADD, w, u);
      apply_cycle(1'b1, 1'b1, w, u, 1'b0, 1'b0); // Valid input held off by reset
    end
    repeat (2) begin
      encode_illegal(w, u);
      apply_cycle(1'b0, 1'b0, w, u, 1'b0, 1'b0); // Quiet after reset
    end
    for (int i = 0; i < N_VEC; i++) begin
      r  = $random(seed);
      pc = pc + 32'd4;
      if (i < 40 || r[3:0] > 4'd3) begin
        idx = (i < 40) ? 6'(i) : 6'($unsigned($random(seed)) % 40); // Sweep first
        encode_kept(rv_op_e'(idx), w, u);
      end else begin
        encode_illegal(w, u);
      end
      u.pc = pc;
      apply_cycle(1'b0, r[6:4] != 3'd0, w, u, r[7], r[9:8] == 2'b11);
    end
    repeat (3) begin
      encode_illegal(w, u);
      apply_cycle(1'b0, 1'b0, w, u, 1'b0, 1'b0);
    end
    @(negedge clk);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- logic/rv_decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module rv_decode_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ifu_vld,
  input  rv_decode_pkg::rv_inst_u ifu_inst,
  input  logic [`RV_XLEN-1:0]     ifu_pc,
  input  logic                    alu_vld,
  input  logic                    alu_br_miss,
  output logic                    idu_vld,
  output rv_decode_pkg::rv_uop_s  idu_uop
);
  import rv_decode_pkg::*;

  rv_op_e   op;
  rv_fmt_e  fmt;
  rv_opnd_s opnd;

  rv_op_decode i_op_decode (
    .inst (ifu_inst),
    .op   (op),
    .fmt  (fmt)
  );

  rv_operand_gen i_operand_gen (
    .inst (ifu_inst),
    .fmt  (fmt),
    .opnd (opnd)
  );

  rv_decode_reg i_decode_reg (
    .clk         (clk),
    .rst         (rst),
    .ifu_vld     (ifu_vld),
    .ifu_pc      (ifu_pc),
    .op          (op),
    .opnd        (opnd),
    .alu_vld     (alu_vld),
    .alu_br_miss (alu_br_miss),
    .idu_vld     (idu_vld),
    .idu_uop     (idu_uop)
  );

endmodule

//--- logic/rv_decode_reg.sv
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module rv_decode_reg (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ifu_vld,
  input  logic [`RV_XLEN-1:0]     ifu_pc,
  input  rv_decode_pkg::rv_op_e   op,
  input  rv_decode_pkg::rv_opnd_s opnd,
  input  logic                    alu_vld,
  input  logic                    alu_br_miss,
  output logic                    idu_vld,
  output rv_decode_pkg::rv_uop_s  idu_uop
);

  logic flush;

  assign flush = alu_vld & alu_br_miss; // Miss only counts with a valid ALU result

  always_ff @(posedge clk) begin
    if (rst) begin
      idu_vld <= 1'b0;
    end else begin
      idu_vld <= ifu_vld & ~flush;
    end
  end

  always_ff @(posedge clk) begin
    idu_uop.op   <= op;
    idu_uop.opnd <= opnd;
    idu_uop.pc   <= ifu_pc;
  end

  a_rst_clears_vld: assert property (@(posedge clk) rst |=> !idu_vld)
    else $error("idu_vld high after reset cycle");

  a_flush_clears_vld: assert property (@(posedge clk) disable iff (rst) flush |=> !idu_vld)
    else $error("idu_vld high after branch-miss flush");

endmodule

//--- logic/rv_operand_gen.sv
`timescale 1ns/1ps

module rv_operand_gen (
  input  rv_decode_pkg::rv_inst_u inst,
  input  rv_decode_pkg::rv_fmt_e  fmt,
  output rv_decode_pkg::rv_opnd_s opnd
);
  import rv_decode_pkg::*;

  always_comb begin
    opnd = '0; // Unused fields stay zero
    case (fmt)
      FMT_R: begin
        opnd.rs1 = inst.r.rs1;
        opnd.rs2 = inst.r.rs2;
        opnd.rd  = inst.r.rd;
      end
      FMT_I: begin
        opnd.rs1       = inst.i.rs1;
        opnd.rd        = inst.i.rd;
        opnd.imm[11:0] = inst.i.imm_11_0;
      end
      FMT_SH: begin
        opnd.rs1      = inst.r.rs1;
        opnd.rd       = inst.r.rd;
        opnd.imm[4:0] = inst.r.rs2; // Shamt sits in the rs2 slot
      end
      FMT_S: begin
        opnd.rs1       = inst.s.rs1;
        opnd.rs2       = inst.s.rs2;
        opnd.imm[11:5] = inst.s.imm_11_5;
        opnd.imm[4:0]  = inst.s.imm_4_0;
      end
      FMT_B: begin
        opnd.rs1       = inst.b.rs1;
        opnd.rs2       = inst.b.rs2;
        opnd.imm[12]   = inst.b.imm_12;
        opnd.imm[11]   = inst.b.imm_11;
        opnd.imm[10:5] = inst.b.imm_10_5;
        opnd.imm[4:1]  = inst.b.imm_4_1;
      end
      FMT_U: begin
        opnd.rd         = inst.u.rd;
        opnd.imm[31:12] = inst.u.imm_31_12;
      end
      FMT_J: begin
        opnd.rd         = inst.j.rd;
        opnd.imm[20]    = inst.j.imm_20;
        opnd.imm[19:12] = inst.j.imm_19_12;
        opnd.imm[11]    = inst.j.imm_11;
        opnd.imm[10:1]  = inst.j.imm_10_1;
      end
      default: opnd = '0;
    endcase
  end

endmodule

//--- logic/rv_op_decode.sv
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module rv_op_decode (
  input  rv_decode_pkg::rv_inst_u inst,
  output rv_decode_pkg::rv_op_e   op,
  output rv_decode_pkg::rv_fmt_e  fmt
);
  import rv_decode_pkg::*;

  always_comb begin
    op = OP_TRAP; // Anything unmatched
    case (inst.r.opcode)
      `RV_OPC_LUI:   op = OP_LUI;
      `RV_OPC_AUIPC: op = OP_AUIPC;
      `RV_OPC_JAL:   op = OP_JAL;
      `RV_OPC_JALR: begin
        if (inst.i.funct3 == 3'b000) op = OP_JALR;
      end
      `RV_OPC_BRANCH: begin
        case (inst.b.funct3)
          3'b000:  op = OP_BEQ;
          3'b001:  op = OP_BNE;
          3'b100:  op = OP_BLT;
          3'b101:  op = OP_BGE;
          3'b110:  op = OP_BLTU;
          3'b111:  op = OP_BGEU;
          default: op = OP_TRAP;
        endcase
      end
      `RV_OPC_LOAD: begin
        case (inst.i.funct3)
          3'b000:  op = OP_LB;
          3'b001:  op = OP_LH;
          3'b010:  op = OP_LW;
          3'b100:  op = OP_LBU;
          3'b101:  op = OP_LHU;
          default: op = OP_TRAP;
        endcase
      end
      `RV_OPC_STORE: begin
        case (inst.s.funct3)
          3'b000:  op = OP_SB;
          3'b001:  op = OP_SH;
          3'b010:  op = OP_SW;
          default: op = OP_TRAP;
        endcase
      end
      `RV_OPC_OP_IMM: begin
        case (inst.i.funct3)
          3'b000: op = OP_ADDI;
          3'b010: op = OP_SLTI;
          3'b011: op = OP_SLTIU;
          3'b100: op = OP_XORI;
          3'b110: op = OP_ORI;
          3'b111: op = OP_ANDI;
          3'b001: begin
            if (inst.r.funct7 == `RV_F7_BASE) op = OP_SLLI;
          end
          3'b101: begin
            case (inst.r.funct7)
              `RV_F7_BASE: op = OP_SRLI;
              `RV_F7_ALT:  op = OP_SRAI;
              default:     op = OP_TRAP;
            endcase
          end
        endcase
      end
      `RV_OPC_OP: begin
        if (inst.r.funct7 == `RV_F7_BASE) begin
          case (inst.r.funct3)
            3'b000: op = OP_ADD;
            3'b001: op = OP_SLL;
            3'b010: op = OP_SLT;
            3'b011: op = OP_SLTU;
            3'b100: op = OP_XOR;
            3'b101: op = OP_SRL;
            3'b110: op = OP_OR;
            3'b111: op = OP_AND;
          endcase
        end else if (inst.r.funct7 == `RV_F7_ALT) begin
          case (inst.r.funct3)
            3'b000:  op = OP_SUB;
            3'b101:  op = OP_SRA;
            default: op = OP_TRAP;
          endcase
        end
      end
      `RV_OPC_FENCE: begin
        if (inst.i.funct3 == 3'b000) op = OP_FENCE; // fm/pred/succ ignored
      end
      `RV_OPC_SYSTEM: begin
        if (inst.i.funct3 == 3'b000) begin
          case (inst.i.imm_11_0)
            `RV_SYS_ECALL:  op = OP_ECALL;
            `RV_SYS_EBREAK: op = OP_EBREAK;
            default:        op = OP_TRAP;
          endcase
        end
        // CSR funct3 values fall through to TRAP
      end
      default: op = OP_TRAP;
    endcase
  end

  always_comb begin
    case (op)
      OP_LUI, OP_AUIPC: fmt = FMT_U;
      OP_JAL:           fmt = FMT_J;
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: fmt = FMT_B;
      OP_JALR, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
      OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI: fmt = FMT_I;
      OP_SLLI, OP_SRLI, OP_SRAI: fmt = FMT_SH;
      OP_SB, OP_SH, OP_SW:       fmt = FMT_S;
      OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
      OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND: fmt = FMT_R;
      default: fmt = FMT_NONE; // FENCE, ECALL, EBREAK, TRAP
    endcase
  end

endmodule

//--- logic/rv_decode_pkg.sv
`include "rv_decode_cfg.svh"

package rv_decode_pkg;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } rv_inst_r_s;

  typedef struct packed {
    logic [11:0]           imm_11_0;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } rv_inst_i_s;

  typedef struct packed {
    logic [6:0]            imm_11_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_4_0;
    logic [6:0]            opcode;
  } rv_inst_s_s;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    logic [6:0]            opcode;
  } rv_inst_b_s;

  typedef struct packed {
    logic [19:0]           imm_31_12;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } rv_inst_u_s;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } rv_inst_j_s;

  // Same 32-bit word seen through each encoding format
  typedef union packed {
    rv_inst_r_s r;
    rv_inst_i_s i;
    rv_inst_s_s s;
    rv_inst_b_s b;
    rv_inst_u_s u;
    rv_inst_j_s j;
  } rv_inst_u;

  typedef enum logic [5:0] {
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_FENCE, OP_ECALL, OP_EBREAK,
    OP_TRAP
  } rv_op_e;

  typedef enum logic [2:0] {
    FMT_R, FMT_I, FMT_SH, FMT_S, FMT_B, FMT_U, FMT_J, FMT_NONE
  } rv_fmt_e;

  typedef struct packed {
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   imm; // Not sign-extended
  } rv_opnd_s;

  typedef struct packed {
    rv_op_e              op;
    rv_opnd_s            opnd;
    logic [`RV_XLEN-1:0] pc;
  } rv_uop_s;

endpackage

//--- logic/rv_decode_cfg.svh
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

`define RV_XLEN   32
`define RV_REG_AW 5

`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP     7'b0110011
`define RV_OPC_FENCE  7'b0001111
`define RV_OPC_SYSTEM 7'b1110011

`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000 // SUB and SRA/SRAI

`define RV_SYS_ECALL  12'h000
`define RV_SYS_EBREAK 12'h001

`endif
